// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
    --top-module tb_soc_interconnect -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST PASSED" sim.log && exit 0 || exit 1

// File: src/addr_decode.sv
/*
 * Address decoder for the core data port.
 * Splits the address into device and sub-device code and raises
 * the per-target strobes in the same cycle as the request.
 * DRAM strobes stay low until the boot loader has finished.
 */
`timescale 1ns/1ps
`default_nettype none

module addr_decode
    import soc_map_pkg::*;
    import mem_access_pkg::*;
(
    input  word_t     data_addr,
    input  wire       data_we,
    input  wire       data_re,
    input  wire       init_done,
    output dev_code_t dev,
    output dev_code_t virt,
    output logic      core_dram_rd,
    output logic      core_dram_wr,
    output logic      clint_we,
    output logic      plic_we,
    output logic      plic_re,
    output logic      fb_we,
    output logic      tohost_we
);

    logic is_dram;
    logic is_fb;

    assign dev  = data_addr[31:28];
    assign virt = data_addr[27:24];

    // Both DRAM aliases
    assign is_dram = (dev == DEV_DRAM) || (dev == DEV_DRAM_LOW);
    assign is_fb   = (dev == DEV_VIRTIO) && (virt == VIRT_FB);

    // Core may touch DRAM only once the image is in place
    assign core_dram_rd = data_re && is_dram && init_done;
    assign core_dram_wr = data_we && is_dram && init_done;

    assign clint_we = data_we && (dev == DEV_CLINT);
    assign plic_we  = data_we && (dev == DEV_PLIC);
    assign plic_re  = data_re && (dev == DEV_PLIC);
    assign fb_we    = data_we && is_fb;

    // Exact match on the host command register
    assign tohost_we = data_we && (data_addr == TOHOST_ADDR);

endmodule

`default_nettype wire

// File: src/boot_loader_seq.sv
/*
 * Boot image loader sequencer.
 * Accepts one loader word per cycle: first KERNEL_BYTES/4 words from
 * address 0, then DTB_BYTES/4 words from DTB_START. Keeps a wrapping
 * sum of all accepted words. Words offered after the last one are ignored.
 */
`timescale 1ns/1ps
`default_nettype none

module boot_loader_seq
    import mem_access_pkg::*;
#(
    parameter int unsigned KERNEL_BYTES = 4096,
    parameter int unsigned DTB_BYTES    = 1024,
    parameter int unsigned DTB_START    = 32'h0010_0000
) (
    input  wire         CLK,
    input  wire         rst,
    input  wire         loader_we,
    input  word_t       loader_data,
    output boot_phase_t boot_phase,
    output word_t       boot_addr,
    output logic        init_done,
    output word_t       checksum
);

    // Address of the final word in each phase
    localparam word_t KERNEL_LAST = word_t'(KERNEL_BYTES - 4);
    localparam word_t DTB_LAST    = word_t'(DTB_START + DTB_BYTES - 4);

    logic accept;

    assign accept    = loader_we && (boot_phase != BOOT_DONE);
    assign init_done = (boot_phase == BOOT_DONE);

    always_ff @(posedge CLK) begin
        if (rst) begin
            boot_phase <= BOOT_KERNEL;
            boot_addr  <= '0;
            checksum   <= '0;
        end else if (accept) begin
            checksum <= checksum + loader_data;
            case (boot_phase)
                BOOT_KERNEL: begin
                    if (boot_addr == KERNEL_LAST) begin
                        boot_phase <= BOOT_DTB;
                        boot_addr  <= word_t'(DTB_START);
                    end else begin
                        boot_addr <= boot_addr + 32'd4;
                    end
                end
                BOOT_DTB: begin
                    if (boot_addr == DTB_LAST) begin
                        boot_phase <= BOOT_DONE;
                    end else begin
                        boot_addr <= boot_addr + 32'd4;
                    end
                end
                default: begin
                    boot_phase <= BOOT_DONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/dram_port_mux.sv
/*
 * DRAM port multiplexer.
 * While booting, loader words go to DRAM as word stores at the
 * loader address. Afterwards core accesses pass through with the
 * offset mask applied, dropped in any cycle where DRAM is busy.
 */
`timescale 1ns/1ps
`default_nettype none

module dram_port_mux
    import soc_map_pkg::*;
    import mem_access_pkg::*;
(
    input  boot_phase_t boot_phase,
    input  word_t       boot_addr,
    input  wire         loader_we,
    input  word_t       loader_data,
    input  wire         core_dram_rd,
    input  wire         core_dram_wr,
    input  word_t       data_addr,
    input  word_t       data_wdata,
    input  ld_ctrl_t    data_ctrl,
    input  wire         dram_busy,
    output logic        dram_rd_en,
    output logic        dram_wr_en,
    output word_t       dram_addr,
    output word_t       dram_wdata,
    output ld_ctrl_t    dram_ctrl,
    output logic        dram_access
);

    logic booting;

    assign booting = (boot_phase != BOOT_DONE);

    // Loader owns the port until boot is done; it is not busy-gated
    assign dram_rd_en = !booting && core_dram_rd && !dram_busy;
    assign dram_wr_en = booting ? loader_we : (core_dram_wr && !dram_busy);

    assign dram_addr  = booting ? boot_addr   : (data_addr & DRAM_OFFSET_MASK);
    assign dram_wdata = booting ? loader_data : data_wdata;
    assign dram_ctrl  = booting ? CTRL_SW     : data_ctrl;

    // Tells the read path to latch address and control
    assign dram_access = dram_rd_en || dram_wr_en;

endmodule

`default_nettype wire

// File: src/host_cmd.sv
/*
 * Host command register (tohost).
 * A print command produces a single-cycle character strobe and then
 * clears itself. A power-off command latches finish until reset.
 */
`timescale 1ns/1ps
`default_nettype none

module host_cmd
    import soc_map_pkg::*;
    import mem_access_pkg::*;
(
    input  wire        CLK,
    input  wire        rst,
    input  wire        tohost_we,
    input  word_t      data_wdata,
    output logic       host_char_we,
    output logic [7:0] host_char,
    output logic       finish
);

    word_t tohost;
    logic  is_print;
    logic  is_power_off;

    assign is_print     = (tohost[31:16] == CMD_PRINT_CHAR);
    assign is_power_off = (tohost[31:16] == CMD_POWER_OFF);

    always_ff @(posedge CLK) begin
        if (rst) begin
            tohost       <= '0;
            host_char_we <= 1'b0;
            finish       <= 1'b0;
        end else begin
            if (tohost_we) begin
                tohost <= data_wdata;
            end else if (is_print) begin
                // Consumed in the same edge that raises the strobe
                tohost <= '0;
            end
            host_char_we <= is_print;
            finish       <= finish || is_power_off;
        end
    end

    always_ff @(posedge CLK) begin
        if (is_print) begin
            host_char <= tohost[7:0];
        end
    end

endmodule

`default_nettype wire

// File: src/mem_access_pkg.sv
/*
 * Data types of the memory access path.
 * Bus words, DRAM lines, the funct3 load/store code and the
 * phases of the boot image loader.
 */
`default_nettype none

package mem_access_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;

    // RISC-V funct3: bit 2 = unsigned, bits 1..0 = byte/half/word
    typedef logic [2:0] ld_ctrl_t;

    localparam ld_ctrl_t CTRL_SW = 3'b010;

    // Loader runs kernel first, then the device tree
    typedef enum logic [1:0] {
        BOOT_KERNEL = 2'd0,
        BOOT_DTB    = 2'd1,
        BOOT_DONE   = 2'd2
    } boot_phase_t;

endpackage

`default_nettype wire

// File: src/read_return.sv
/*
 * Read data return path.
 * Remembers which target the previous cycle addressed and, for DRAM,
 * the byte offset and load width of the access. One cycle later it
 * aligns the DRAM line and extends it, or selects peripheral data.
 */
`timescale 1ns/1ps
`default_nettype none

module read_return
    import soc_map_pkg::*;
    import mem_access_pkg::*;
(
    input  wire       CLK,
    input  wire       rst,
    input  dev_code_t dev,
    input  dev_code_t virt,
    input  wire       dram_access,
    input  word_t     dram_addr,
    input  ld_ctrl_t  dram_ctrl,
    input  line_t     dram_rdata,
    input  word_t     clint_rdata,
    input  word_t     plic_rdata,
    input  word_t     fb_rdata,
    output word_t     data_rdata,
    output logic      data_from_dram
);

    dev_code_t  dev_q;
    dev_code_t  virt_q;
    logic [3:0] offset_q;
    ld_ctrl_t   ctrl_q;

    line_t      line_shifted;
    word_t      raw_word;
    word_t      load_word;
    logic       sign_fill;

    always_ff @(posedge CLK) begin
        if (rst) begin
            dev_q  <= DEV_DRAM_LOW;
            virt_q <= '0;
        end else begin
            dev_q  <= dev;
            virt_q <= virt;
        end
    end

    // Only the byte lane within the 16-byte line matters
    always_ff @(posedge CLK) begin
        if (dram_access) begin
            offset_q <= dram_addr[3:0];
            ctrl_q   <= dram_ctrl;
        end
    end

    assign line_shifted = dram_rdata >> {offset_q, 3'b000};
    assign raw_word     = line_shifted[31:0];

    always_comb begin
        case (ctrl_q[1:0])
            2'd0: begin
                sign_fill = raw_word[7] && !ctrl_q[2];
                load_word = {{24{sign_fill}}, raw_word[7:0]};
            end
            2'd1: begin
                sign_fill = raw_word[15] && !ctrl_q[2];
                load_word = {{16{sign_fill}}, raw_word[15:0]};
            end
            default: begin
                sign_fill = 1'b0;
                load_word = raw_word;
            end
        endcase
    end

    // Anything not a known peripheral is treated as DRAM
    always_comb begin
        data_from_dram = 1'b0;
        case (dev_q)
            DEV_CLINT:  data_rdata = clint_rdata;
            DEV_PLIC:   data_rdata = plic_rdata;
            DEV_VIRTIO: data_rdata = (virt_q == VIRT_FB) ? fb_rdata : '0;
            default: begin
                data_rdata     = load_word;
                data_from_dram = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/soc_interconnect.sv
/*
 * Memory-side interconnect top level.
 * Connects the core data port to DRAM, CLINT, PLIC and framebuffer,
 * runs the boot image loader and the host command register.
 * Boot image sizes and device tree address are set here.
 */
`timescale 1ns/1ps
`default_nettype none

module soc_interconnect
    import soc_map_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int unsigned KERNEL_BYTES = 4096,
    parameter int unsigned DTB_BYTES    = 1024,
    parameter int unsigned DTB_START    = 32'h0010_0000
) (
    input  wire        CLK,
    input  wire        rst,
    // Core data port
    input  word_t      data_addr,
    input  word_t      data_wdata,
    input  wire        data_we,
    input  wire        data_re,
    input  ld_ctrl_t   data_ctrl,
    output word_t      data_rdata,
    output logic       data_from_dram,
    // DRAM
    output logic       dram_rd_en,
    output logic       dram_wr_en,
    output word_t      dram_addr,
    output word_t      dram_wdata,
    output ld_ctrl_t   dram_ctrl,
    input  wire        dram_busy,
    input  line_t      dram_rdata,
    // Peripherals
    output logic       clint_we,
    output word_t      clint_wdata,
    output logic       plic_we,
    output logic       plic_re,
    output word_t      plic_wdata,
    output logic       fb_we,
    output word_t      fb_wdata,
    input  word_t      clint_rdata,
    input  word_t      plic_rdata,
    input  word_t      fb_rdata,
    // Boot loader
    input  wire        loader_we,
    input  word_t      loader_data,
    output logic       init_done,
    output word_t      checksum,
    // Host
    output logic       host_char_we,
    output logic [7:0] host_char,
    output logic       finish
);

    dev_code_t   dev;
    dev_code_t   virt;
    logic        core_dram_rd;
    logic        core_dram_wr;
    logic        tohost_we;
    logic        dram_access;
    boot_phase_t boot_phase;
    word_t       boot_addr;

    assign clint_wdata = data_wdata;
    assign plic_wdata  = data_wdata;
    assign fb_wdata    = data_wdata;

    addr_decode i_addr_decode (
        .data_addr    (data_addr),
        .data_we      (data_we),
        .data_re      (data_re),
        .init_done    (init_done),
        .dev          (dev),
        .virt         (virt),
        .core_dram_rd (core_dram_rd),
        .core_dram_wr (core_dram_wr),
        .clint_we     (clint_we),
        .plic_we      (plic_we),
        .plic_re      (plic_re),
        .fb_we        (fb_we),
        .tohost_we    (tohost_we)
    );

    boot_loader_seq #(
        .KERNEL_BYTES (KERNEL_BYTES),
        .DTB_BYTES    (DTB_BYTES),
        .DTB_START    (DTB_START)
    ) i_boot_loader_seq (
        .CLK         (CLK),
        .rst         (rst),
        .loader_we   (loader_we),
        .loader_data (loader_data),
        .boot_phase  (boot_phase),
        .boot_addr   (boot_addr),
        .init_done   (init_done),
        .checksum    (checksum)
    );

    dram_port_mux i_dram_port_mux (
        .boot_phase   (boot_phase),
        .boot_addr    (boot_addr),
        .loader_we    (loader_we),
        .loader_data  (loader_data),
        .core_dram_rd (core_dram_rd),
        .core_dram_wr (core_dram_wr),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_ctrl    (data_ctrl),
        .dram_busy    (dram_busy),
        .dram_rd_en   (dram_rd_en),
        .dram_wr_en   (dram_wr_en),
        .dram_addr    (dram_addr),
        .dram_wdata   (dram_wdata),
        .dram_ctrl    (dram_ctrl),
        .dram_access  (dram_access)
    );

    read_return i_read_return (
        .CLK            (CLK),
        .rst            (rst),
        .dev            (dev),
        .virt           (virt),
        .dram_access    (dram_access),
        .dram_addr      (dram_addr),
        .dram_ctrl      (dram_ctrl),
        .dram_rdata     (dram_rdata),
        .clint_rdata    (clint_rdata),
        .plic_rdata     (plic_rdata),
        .fb_rdata       (fb_rdata),
        .data_rdata     (data_rdata),
        .data_from_dram (data_from_dram)
    );

    host_cmd i_host_cmd (
        .CLK          (CLK),
        .rst          (rst),
        .tohost_we    (tohost_we),
        .data_wdata   (data_wdata),
        .host_char_we (host_char_we),
        .host_char    (host_char),
        .finish       (finish)
    );

endmodule

`default_nettype wire

// File: src/soc_map_pkg.sv
/*
 * System address map of the SoC interconnect.
 * Device codes live in the top address nibble; inside the VirtIO
 * window the next nibble selects the sub-device.
 * Also holds the host command codes written to the tohost register.
 */
`default_nettype none

package soc_map_pkg;

    // Top 4 address bits
    typedef logic [3:0] dev_code_t;

    localparam dev_code_t DEV_DRAM_LOW = 4'h0;
    localparam dev_code_t DEV_DRAM     = 4'h8;
    localparam dev_code_t DEV_VIRTIO   = 4'h4;
    localparam dev_code_t DEV_PLIC     = 4'h5;
    localparam dev_code_t DEV_CLINT    = 4'h6;

    // Sub-device in address bits 27..24
    localparam dev_code_t VIRT_FB = 4'h5;

    // DRAM is addressed by its low 27 bits only
    localparam logic [31:0] DRAM_OFFSET_MASK = 32'h07ff_ffff;

    // Host command register, sits in VirtIO sub-device 0
    localparam logic [31:0] TOHOST_ADDR = 32'h4000_8000;

    // Command codes in the upper half of the tohost word
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0001;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0002;

endpackage

`default_nettype wire

// File: tb.f
src/soc_map_pkg.sv
src/mem_access_pkg.sv
src/addr_decode.sv
src/dram_port_mux.sv
src/boot_loader_seq.sv
src/read_return.sv
src/host_cmd.sv
src/soc_interconnect.sv
tests/interconnect_sva.sv
tests/tb_soc_interconnect.sv

// File: tests/interconnect_sva.sv
/*
 * Assertions bound into the interconnect top level.
 * Covers DRAM strobe exclusivity, busy gating of the strobes
 * and the quiet state of the host outputs after reset.
 */
`timescale 1ns/1ps
`default_nettype none

module interconnect_sva (
    input wire CLK,
    input wire rst,
    input wire dram_rd_en,
    input wire dram_wr_en,
    input wire dram_busy,
    input wire finish,
    input wire host_char_we
);

    // One DRAM command per cycle
    rd_wr_exclusive: assert property (@(posedge CLK) !(dram_rd_en && dram_wr_en))
        else $error("dram_rd_en and dram_wr_en high in the same cycle");

    no_strobe_when_busy: assert property (@(posedge CLK) dram_busy |-> !(dram_rd_en || dram_wr_en))
        else $error("DRAM strobe raised while dram_busy is high");

    // Checked one edge after a reset edge
    host_quiet_in_reset: assert property (@(posedge CLK) rst |=> (!finish && !host_char_we))
        else $error("finish or host_char_we high after a reset edge");

endmodule

bind soc_interconnect interconnect_sva i_sva (
    .CLK          (CLK),
    .rst          (rst),
    .dram_rd_en   (dram_rd_en),
    .dram_wr_en   (dram_wr_en),
    .dram_busy    (dram_busy),
    .finish       (finish),
    .host_char_we (host_char_we)
);

`default_nettype wire

// File: tests/tb_soc_interconnect.sv
/*
 * Directed testbench for the SoC memory interconnect.
 * Streams a boot image, then runs DRAM loads and stores, busy
 * back-pressure, peripheral decode, host commands and a second
 * reset against a small line-based DRAM model.
 * Inputs change on the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_interconnect
    import soc_map_pkg::*;
    import mem_access_pkg::*;
();

    // Small boot image so the load phase stays short
    localparam int unsigned KERNEL_BYTES = 32;
    localparam int unsigned DTB_BYTES    = 16;
    localparam int unsigned DTB_START    = 32'h0000_0100;
    localparam int          KERNEL_WORDS = KERNEL_BYTES / 4;
    localparam int          TIMEOUT      = 20;

    logic       CLK;
    logic       rst;
    word_t      data_addr;
    word_t      data_wdata;
    logic       data_we;
    logic       data_re;
    ld_ctrl_t   data_ctrl;
    word_t      data_rdata;
    logic       data_from_dram;
    logic       dram_rd_en;
    logic       dram_wr_en;
    word_t      dram_addr;
    word_t      dram_wdata;
    ld_ctrl_t   dram_ctrl;
    logic       dram_busy;
    line_t      dram_rdata = '0;
    logic       clint_we;
    word_t      clint_wdata;
    logic       plic_we;
    logic       plic_re;
    word_t      plic_wdata;
    logic       fb_we;
    word_t      fb_wdata;
    word_t      clint_rdata;
    word_t      plic_rdata;
    word_t      fb_rdata;
    logic       loader_we;
    word_t      loader_data;
    logic       init_done;
    word_t      checksum;
    logic       host_char_we;
    logic [7:0] host_char;
    logic       finish;

    word_t lfsr_state;
    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;

    line_t dram_mem [0:63];

    soc_interconnect #(
        .KERNEL_BYTES (KERNEL_BYTES),
        .DTB_BYTES    (DTB_BYTES),
        .DTB_START    (DTB_START)
    ) i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Every word of the fill differs and carries its own byte address
    function automatic line_t fill_line(input int unsigned idx);
        line_t l;
        word_t a;
        for (int j = 0; j < 4; j++) begin
            a = word_t'(idx * 16 + j * 4);
            l[32*j +: 32] = 32'hd5a0_0000 ^ a;
        end
        return l;
    endfunction

    // DRAM model, 64 lines, read data valid the cycle after the strobe
    always @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                dram_mem[i] <= fill_line(i);
            end
        end else begin
            if (dram_rd_en) begin
                dram_rdata <= dram_mem[dram_addr[9:4]];
            end
            // Only word stores are modelled
            if (dram_wr_en) begin
                dram_mem[dram_addr[9:4]][{dram_addr[3:2], 5'b0} +: 32] <= dram_wdata;
            end
        end
    end

    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], next_rand_bit()};
        end
        return v;
    endfunction

    // Bytes past the end of the line read as zero
    function automatic word_t expect_load(input line_t line, input int off, input ld_ctrl_t ctrl);
        logic [7:0] b [4];
        word_t      w;
        for (int k = 0; k < 4; k++) begin
            b[k] = (off + k < 16) ? line[8*(off+k) +: 8] : 8'h00;
        end
        case (ctrl[1:0])
            2'd0:    w = {{24{b[0][7] & ~ctrl[2]}}, b[0]};
            2'd1:    w = {{16{b[1][7] & ~ctrl[2]}}, b[1], b[0]};
            default: w = {b[3], b[2], b[1], b[0]};
        endcase
        return w;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic drive_idle();
        data_addr   = '0;
        data_wdata  = '0;
        data_we     = 1'b0;
        data_re     = 1'b0;
        data_ctrl   = '0;
        loader_we   = 1'b0;
        loader_data = '0;
    endtask

    task automatic start_core_request(input word_t addr, input logic is_write,
                                      input word_t wdata, input ld_ctrl_t ctrl);
        data_addr  = addr;
        data_we    = is_write;
        data_re    = !is_write;
        data_wdata = wdata;
        data_ctrl  = ctrl;
    endtask

    // Holds the request until a strobe, returns at the next falling edge
    task automatic wait_dram_strobe(input logic is_write, input word_t addr);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            #1;
            seen = is_write ? dram_wr_en : dram_rd_en;
            if (!seen) begin
                @(negedge CLK);
                n++;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: no DRAM %s strobe for address %h",
                     is_write ? "write" : "read", addr);
        end else begin
            check_value("dram_addr", dram_addr, {5'b0, addr[26:0]});
        end
        @(negedge CLK);
        drive_idle();
    endtask

    task automatic core_dram_access(input word_t addr, input logic is_write,
                                    input word_t wdata, input ld_ctrl_t ctrl);
        @(negedge CLK);
        start_core_request(addr, is_write, wdata, ctrl);
        wait_dram_strobe(is_write, addr);
    endtask

    task automatic wait_host_flag(input logic want_finish, output int cycles);
        logic seen;
        cycles = 0;
        #1;
        seen = want_finish ? finish : host_char_we;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge CLK);
            #1;
            cycles++;
            seen = want_finish ? finish : host_char_we;
        end
        if (!seen) begin
            errors++;
            $display("timeout: %s never went high", want_finish ? "finish" : "host_char_we");
        end
    endtask

    task automatic write_tohost(input word_t w);
        @(negedge CLK);
        data_addr  = TOHOST_ADDR;
        data_we    = 1'b1;
        data_wdata = w;
        @(negedge CLK);
        drive_idle();
    endtask

    task automatic boot_load();
        int    e0;
        word_t w;
        word_t sum;
        word_t exp_addr;
        e0 = errors;
        sum = '0;
        #1;
        check_value("init_done", word_t'(init_done), 32'd0);
        check_value("checksum", checksum, 32'd0);
        check_value("finish", word_t'(finish), 32'd0);
        check_value("host_char_we", word_t'(host_char_we), 32'd0);
        for (int i = 0; i < KERNEL_WORDS + int'(DTB_BYTES / 4); i++) begin
            @(negedge CLK);
            w = rand_bits(32);
            exp_addr = (i < KERNEL_WORDS) ? word_t'(4 * i)
                                          : word_t'(DTB_START + 4 * (i - KERNEL_WORDS));
            loader_we   = 1'b1;
            loader_data = w;
            #1;
            check_value("init_done", word_t'(init_done), 32'd0);
            check_value("dram_wr_en", word_t'(dram_wr_en), 32'd1);
            check_value("dram_addr", dram_addr, exp_addr);
            check_value("dram_wdata", dram_wdata, w);
            check_value("dram_ctrl", word_t'(dram_ctrl), 32'd2);
            sum = sum + w;
        end
        @(negedge CLK);
        drive_idle();
        #1;
        check_value("init_done", word_t'(init_done), 32'd1);
        check_value("checksum", checksum, sum);
        // A late loader word must be ignored
        @(negedge CLK);
        loader_we   = 1'b1;
        loader_data = rand_bits(32);
        #1;
        check_value("dram_wr_en", word_t'(dram_wr_en), 32'd0);
        @(negedge CLK);
        drive_idle();
        #1;
        check_value("checksum", checksum, sum);
        report_test("boot_load", e0);
    endtask

    task automatic dram_loads();
        int       e0;
        line_t    line;
        ld_ctrl_t ctrls [5];
        e0 = errors;
        ctrls = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        for (int k = 0; k < 4; k++) begin
            line[32*k +: 32] = rand_bits(32);
            core_dram_access(word_t'(32'h8000_0200 + 4 * k), 1'b1, line[32*k +: 32], 3'b010);
        end
        for (int off = 0; off < 16; off++) begin
            for (int c = 0; c < 5; c++) begin
                core_dram_access(word_t'(32'h8000_0200 + off), 1'b0, '0, ctrls[c]);
                #1;
                check_value("data_rdata", data_rdata, expect_load(line, off, ctrls[c]));
                check_value("data_from_dram", word_t'(data_from_dram), 32'd1);
            end
        end
        report_test("dram_loads", e0);
    endtask

    task automatic dram_store_busy();
        int    e0;
        word_t w;
        e0 = errors;
        // Upper offset bits above the DRAM window must be masked off
        w = rand_bits(32);
        core_dram_access(32'h8a00_0124, 1'b1, w, 3'b010);
        core_dram_access(32'h8a00_0124, 1'b0, '0, 3'b010);
        #1;
        check_value("data_rdata", data_rdata, w);
        // Store, then load, each first held off by busy
        w = rand_bits(32);
        for (int pass = 0; pass < 2; pass++) begin
            @(negedge CLK);
            dram_busy = 1'b1;
            start_core_request(32'h0000_0130, pass == 0, w, 3'b010);
            repeat (3) begin
                #1;
                check_value("dram_wr_en", word_t'(dram_wr_en), 32'd0);
                check_value("dram_rd_en", word_t'(dram_rd_en), 32'd0);
                @(negedge CLK);
            end
            dram_busy = 1'b0;
            wait_dram_strobe(pass == 0, 32'h0000_0130);
        end
        #1;
        check_value("data_rdata", data_rdata, w);
        report_test("dram_store_busy", e0);
    endtask

    // exp_we holds the expected clint, plic and fb write strobes
    task automatic peripheral_access(input word_t addr, input logic [2:0] exp_we,
                                     input word_t exp_rdata);
        word_t wd;
        wd = rand_bits(32);
        @(negedge CLK);
        data_addr  = addr;
        data_we    = 1'b1;
        data_wdata = wd;
        #1;
        check_value("clint_we", word_t'(clint_we), word_t'(exp_we[2]));
        check_value("plic_we", word_t'(plic_we), word_t'(exp_we[1]));
        check_value("fb_we", word_t'(fb_we), word_t'(exp_we[0]));
        check_value("dram_wr_en", word_t'(dram_wr_en), 32'd0);
        check_value("clint_wdata", clint_wdata, wd);
        check_value("plic_wdata", plic_wdata, wd);
        check_value("fb_wdata", fb_wdata, wd);
        @(negedge CLK);
        data_we = 1'b0;
        data_re = 1'b1;
        #1;
        check_value("plic_re", word_t'(plic_re), word_t'(exp_we[1]));
        check_value("dram_rd_en", word_t'(dram_rd_en), 32'd0);
        @(negedge CLK);
        drive_idle();
        #1;
        check_value("data_rdata", data_rdata, exp_rdata);
        check_value("data_from_dram", word_t'(data_from_dram), 32'd0);
    endtask

    task automatic peripheral_decode();
        int e0;
        e0 = errors;
        @(negedge CLK);
        clint_rdata = rand_bits(32);
        plic_rdata  = rand_bits(32);
        fb_rdata    = rand_bits(32);
        peripheral_access(32'h6000_4000, 3'b100, clint_rdata);
        peripheral_access(32'h5020_0004, 3'b010, plic_rdata);
        peripheral_access(32'h4500_0100, 3'b001, fb_rdata);
        // VirtIO sub-device other than the framebuffer
        peripheral_access(32'h4200_0000, 3'b000, 32'd0);
        report_test("peripheral_decode", e0);
    endtask

    task automatic host_commands();
        int         e0;
        int         n;
        word_t      r;
        logic [7:0] ch;
        e0 = errors;
        r = rand_bits(8);
        ch = r[7:0];
        write_tohost({CMD_PRINT_CHAR, 8'h00, ch});
        wait_host_flag(1'b0, n);
        check_value("host_char_we delay", word_t'(n), 32'd1);
        check_value("host_char", word_t'(host_char), word_t'(ch));
        @(negedge CLK);
        #1;
        check_value("host_char_we", word_t'(host_char_we), 32'd0);
        check_value("finish", word_t'(finish), 32'd0);
        write_tohost({CMD_POWER_OFF, 16'h0000});
        wait_host_flag(1'b1, n);
        check_value("finish delay", word_t'(n), 32'd1);
        repeat (5) begin
            @(negedge CLK);
            #1;
            check_value("finish", word_t'(finish), 32'd1);
            check_value("host_char_we", word_t'(host_char_we), 32'd0);
        end
        report_test("host_commands", e0);
    endtask

    // Reset again with finish set and the boot image loaded
    task automatic reset_state();
        int e0;
        e0 = errors;
        @(negedge CLK);
        rst = 1'b1;
        repeat (3) begin
            @(negedge CLK);
            #1;
            check_value("finish", word_t'(finish), 32'd0);
            check_value("host_char_we", word_t'(host_char_we), 32'd0);
            check_value("init_done", word_t'(init_done), 32'd0);
            check_value("checksum", checksum, 32'd0);
        end
        @(negedge CLK);
        rst = 1'b0;
        report_test("reset_state", e0);
    endtask

    initial begin
        lfsr_state   = 32'h77cb_ccf8;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        dram_busy    = 1'b0;
        clint_rdata  = '0;
        plic_rdata   = '0;
        fb_rdata     = '0;
        drive_idle();
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;

        boot_load();
        dram_loads();
        dram_store_busy();
        peripheral_decode();
        host_commands();
        reset_state();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
